// ==== testbench/erx_testdata.txt ====
# columns: command, operand (hex word for E/S, decimal otherwise), count for E/S
# T name | L R D level | H idle | P U check | G W wait | E S word n | C B X n | K
T hold_off
P 1
U 0
H 64
P 1
U 0
T bring_up
D 0
G 0
H 48
U 0
L 1
R 1
W 1
P 0
T in_order
E 11110001 3
S 11110001 3
B 3
C 3
T credit_stall
E a0000001 6
S a0000001 6
B 4
X 20
C 1
B 1
X 10
C 1
B 1
C 4
T input_credits
K
T soft_flush
E b0000001 4
S b0000001 6
B 4
X 10
D 1
W 0
P 1
D 0
W 1
E c0000001 5
S c0000001 5
B 4
X 20
C 1
B 1
K

// ==== src.f ====
+incdir+src
src/erx_pkg.sv
src/erx_heartbeat_timer.sv
src/erx_reset_fsm.sv
src/erx_rx_fifo.sv
src/erx_credit_tx.sv
src/erx_core_top.sv
testbench/erx_tb.sv

// ==== Makefile ====
# Verilator build and run for the link receive core

VERILATOR ?= verilator
TOP       ?= erx_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(FILELIST) $(wildcard src/*.sv src/*.svh testbench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/erx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "erx_consts.svh"

module erx_tb;

   import erx_pkg::*;

   localparam int WAIT_LIMIT = 400;   // cycles allowed per wait loop

   logic      sys_clk;
   logic      rx_reset;
   logic      soft_disable;
   logic      pll_locked;
   logic      delay_ready;
   logic      pll_reset;
   logic      delay_reset;
   logic      link_up;
   logic      in_valid;
   erx_beat_t in_beat;
   logic      in_credit;
   logic      out_valid;
   erx_beat_t out_beat;
   logic      out_credit;

   erx_beat_t expect_q[$];   // beats still owed by the dut in order
   int        beats_seen;    // out beats over the whole run
   int        beats_mark;    // out beats already claimed by B commands
   int        sent_count;    // beats sent since link-up
   int        credit_back;   // in_credit pulses since link-up
   int        errors;
   int        test_errors;
   int        test_count;
   int        seed;
   string     test_name;

   erx_core_top u_dut (
      .sys_clk      (sys_clk),
      .rx_reset     (rx_reset),
      .soft_disable (soft_disable),
      .pll_locked   (pll_locked),
      .delay_ready  (delay_ready),
      .pll_reset    (pll_reset),
      .delay_reset  (delay_reset),
      .link_up      (link_up),
      .in_valid     (in_valid),
      .in_beat      (in_beat),
      .in_credit    (in_credit),
      .out_valid    (out_valid),
      .out_beat     (out_beat),
      .out_credit   (out_credit)
   );

   always #50 sys_clk = ~sys_clk;   // 100 ns period

   //####################################################################
   // checks and bookkeeping
   //####################################################################

   task automatic report_fault(input string msg);
      $display("%s: %s", test_name, msg);
      errors      = errors + 1;
      test_errors = test_errors + 1;
   endtask

   task automatic compare_beat(input erx_beat_t exp, input erx_beat_t act);
      if (act !== exp)
      begin
         $display("ERROR %s: beat expected %h last %0b, actual %h last %0b",
                  test_name, exp.data, exp.last, act.data, act.last);
         errors      = errors + 1;
         test_errors = test_errors + 1;
      end
   endtask

   task automatic compare_level(input string what, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("ERROR %s: %s expected %0b, actual %0b", test_name, what, exp, act);
         errors      = errors + 1;
         test_errors = test_errors + 1;
      end
   endtask

   task automatic compare_count(input erx_credit_t exp, input erx_credit_t act);
      if (act !== exp)
      begin
         $display("ERROR %s: input credits expected %0d, actual %0d", test_name, exp, act);
         errors      = errors + 1;
         test_errors = test_errors + 1;
      end
   endtask

   // frame ends on every word whose low two bits are set
   function automatic erx_beat_t make_beat(input erx_word_t word);
      erx_beat_t b;
      b.data = word;
      b.last = &word[1:0];
      return b;
   endfunction

   function automatic int credits_held();
      return `ERX_FIFO_DEPTH - sent_count + credit_back;   // sender side view
   endfunction

   task automatic finish_test();
      if (test_name != "")
      begin
         if (test_errors == 0)
            $display("test %s: ok", test_name);
         else
            $display("test %s: FAILED, %0d mismatches", test_name, test_errors);
      end
   endtask

   //####################################################################
   // scoreboard on the rising edge
   //####################################################################

   always @(posedge sys_clk)
   begin
      if (out_valid)
      begin
         beats_seen = beats_seen + 1;
         if (expect_q.size() == 0)
            report_fault("a beat came out while none was expected");
         else
            compare_beat(expect_q.pop_front(), out_beat);
      end
      if (in_credit)
      begin
         credit_back = credit_back + 1;
         if (credit_back > sent_count)
            report_fault("an input credit came back for a beat never sent");
      end
   end

   //####################################################################
   // stimulus and wait tasks
   //####################################################################

   task automatic drive_level(input byte which, input logic level);
      @(posedge sys_clk);
      case (which)
         "L"     : pll_locked   <= level;
         "R"     : delay_ready  <= level;
         default : soft_disable <= level;
      endcase
   endtask

   // use_link selects link_up over pll_reset
   task automatic wait_for_level(input logic use_link, input logic level);
      int n;
      n = 0;
      while (((use_link ? link_up : pll_reset) !== level) && n < WAIT_LIMIT)
      begin
         @(negedge sys_clk);
         n = n + 1;
      end
      if ((use_link ? link_up : pll_reset) !== level)
         report_fault($sformatf("timed out waiting for %s to go %0b",
                                use_link ? "link_up" : "pll_reset", level));
   endtask

   task automatic queue_expected(input erx_word_t first, input int count);
      int i;
      for (i = 0; i < count; i++)
         expect_q.push_back(make_beat(first + erx_word_t'(i)));
   endtask

   task automatic send_beats(input erx_word_t first, input int count);
      int i;
      int n;
      int gap;
      for (i = 0; i < count; i++)
      begin
         n = 0;
         while (credits_held() == 0 && n < WAIT_LIMIT)   // never send without a credit
         begin
            @(negedge sys_clk);
            n = n + 1;
         end
         if (credits_held() == 0 || !link_up)
         begin
            report_fault("beat not sent, no input credit came back or the link is down");
            return;
         end
         @(posedge sys_clk);
         in_valid   <= 1'b1;
         in_beat    <= make_beat(first + erx_word_t'(i));
         sent_count = sent_count + 1;
         @(posedge sys_clk);
         in_valid <= 1'b0;
         gap = int'($unsigned($random(seed)) % 3);   // 0..2 idle cycles
         repeat (gap) @(posedge sys_clk);
      end
   endtask

   task automatic return_credits(input int count);
      repeat (count)
      begin
         @(posedge sys_clk);
         out_credit <= 1'b1;   // one-cycle pulse per credit
         @(posedge sys_clk);
         out_credit <= 1'b0;
      end
   endtask

   task automatic wait_beats(input int count);
      int n;
      n = 0;
      while ((beats_seen - beats_mark) < count && n < WAIT_LIMIT)
      begin
         @(negedge sys_clk);
         n = n + 1;
      end
      if ((beats_seen - beats_mark) < count)
         report_fault($sformatf("timed out, only %0d of %0d beats came out",
                                beats_seen - beats_mark, count));
      beats_mark = beats_mark + count;
   endtask

   task automatic check_stall(input int cycles);
      repeat (cycles)
      begin
         @(negedge sys_clk);
         compare_level("out_valid", 1'b0, out_valid);
      end
   endtask

   // every beat delivered means every slot is back with the sender
   task automatic wait_input_credits();
      int n;
      n = 0;
      while (expect_q.size() != 0 && n < WAIT_LIMIT)
      begin
         @(negedge sys_clk);
         n = n + 1;
      end
      if (expect_q.size() != 0)
         report_fault("timed out waiting for the buffered beats to drain");
      else
      begin
         @(negedge sys_clk);   // let the last credit pulse land
         compare_count(erx_credit_t'(`ERX_FIFO_DEPTH), erx_credit_t'(credits_held()));
      end
   endtask

   //####################################################################
   // command interpreter
   //####################################################################

   initial
   begin
      int        fd;
      string     line;
      string     word;
      string     next_name;
      erx_word_t op_word;
      int        op_n;
      int        op_num;
      byte       cmd;

      sys_clk      = 1'b0;
      rx_reset     = 1'b1;
      soft_disable = 1'b1;   // hold off from the start
      pll_locked   = 1'b0;
      delay_ready  = 1'b0;
      in_valid     = 1'b0;
      in_beat      = '0;
      out_credit   = 1'b0;
      seed         = 16340;
      errors       = 0;
      test_errors  = 0;
      test_count   = 0;
      beats_seen   = 0;
      beats_mark   = 0;
      sent_count   = 0;
      credit_back  = 0;
      test_name    = "";

      repeat (8) @(posedge sys_clk);
      rx_reset <= 1'b0;

      fd = $fopen("testbench/erx_testdata.txt", "r");
      if (fd == 0)
         report_fault("cannot open testbench/erx_testdata.txt");
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#")
               continue;                                   // blank or comment
            op_num = 0;
            void'($sscanf(line, "%s %h %d", word, op_word, op_n));   // word ops
            void'($sscanf(line, "%s %d", word, op_num));             // count ops
            cmd = word.getc(0);
            case (cmd)
               "T" :
               begin
                  finish_test();
                  void'($sscanf(line, "%s %s", word, next_name));
                  test_name   = next_name;
                  test_errors = 0;
                  test_count  = test_count + 1;
               end
               "L", "R", "D" : drive_level(cmd, op_num[0]);
               "H" : repeat (op_num) @(posedge sys_clk);
               "P" :
               begin
                  @(negedge sys_clk);
                  compare_level("pll_reset", op_num[0], pll_reset);
                  compare_level("delay_reset", op_num[0], delay_reset);
               end
               "U" :
               begin
                  @(negedge sys_clk);
                  compare_level("link_up", op_num[0], link_up);
               end
               "G" : wait_for_level(1'b0, op_num[0]);
               "W" :
               begin
                  wait_for_level(1'b1, op_num[0]);
                  if (op_num[0])
                  begin
                     sent_count  = 0;   // fresh credit grant per link-up
                     credit_back = 0;
                  end
               end
               "E" : queue_expected(op_word, op_n);
               "S" : send_beats(op_word, op_n);
               "C" : return_credits(op_num);
               "B" : wait_beats(op_num);
               "X" : check_stall(op_num);
               "K" : wait_input_credits();
               default : report_fault($sformatf("unknown testdata command %s", word));
            endcase
         end
         $fclose(fd);
      end

      finish_test();
      if (expect_q.size() != 0)
         report_fault($sformatf("%0d expected beats never came out", expect_q.size()));
      $display("%0d tests, %0d beats out, %0d errors", test_count, beats_seen, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/erx_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module erx_core_top
(
   input  wire                sys_clk,        // system clock
   input  wire                rx_reset,       // power-on reset, async
   input  wire                soft_disable,   // sw hold-off
   // primitive handshake
   input  wire                pll_locked,
   input  wire                delay_ready,
   output logic               pll_reset,
   output logic               delay_reset,
   output logic               link_up,        // core released
   // link side
   input  wire                in_valid,
   input  wire erx_pkg::erx_beat_t in_beat,
   output logic               in_credit,      // one credit back per pulse
   // downstream side
   output logic               out_valid,
   output erx_pkg::erx_beat_t out_beat,
   input  wire                out_credit      // downstream slot freed
);

   import erx_pkg::*;

   logic      heartbeat;
   logic      core_reset;   // to both data modules
   logic      head_valid;
   erx_beat_t head_beat;
   logic      pop;

   //####################################################################
   // reset sequencing
   //####################################################################

   erx_heartbeat_timer u_hb (
      .sys_clk   (sys_clk),
      .rx_reset  (rx_reset),
      .heartbeat (heartbeat)
   );

   erx_reset_fsm u_rst (
      .sys_clk      (sys_clk),
      .rx_reset     (rx_reset),
      .heartbeat    (heartbeat),
      .soft_disable (soft_disable),
      .pll_locked   (pll_locked),
      .delay_ready  (delay_ready),
      .pll_reset    (pll_reset),
      .delay_reset  (delay_reset),
      .core_reset   (core_reset),
      .link_up      (link_up)
   );

   //####################################################################
   // data path
   //####################################################################

   erx_rx_fifo u_fifo (
      .sys_clk    (sys_clk),
      .core_reset (core_reset),
      .in_valid   (in_valid),
      .in_beat    (in_beat),
      .pop        (pop),
      .head_valid (head_valid),
      .head_beat  (head_beat),
      .in_credit  (in_credit)
   );

   erx_credit_tx u_tx (
      .sys_clk    (sys_clk),
      .core_reset (core_reset),
      .head_valid (head_valid),
      .head_beat  (head_beat),
      .out_credit (out_credit),
      .pop        (pop),
      .out_valid  (out_valid),
      .out_beat   (out_beat)
   );

endmodule

`default_nettype wire

// ==== src/erx_credit_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "erx_consts.svh"

module erx_credit_tx
(
   input  wire                sys_clk,       // system clock
   input  wire                core_reset,    // restores credits, async
   input  wire                head_valid,    // buffer has a beat
   input  wire erx_pkg::erx_beat_t head_beat, // oldest buffered beat
   input  wire                out_credit,    // credit back from downstream
   output logic               pop,           // take head from buffer
   output logic               out_valid,     // beat launched
   output erx_pkg::erx_beat_t out_beat       // launched beat
);

   import erx_pkg::*;

   erx_credit_t credits;   // downstream slots we may fill
   logic        launch;

   assign launch = head_valid && (credits != '0);
   assign pop    = launch;

   //####################################################################
   // credit counter and launch flag
   //####################################################################

   always_ff @(posedge sys_clk or posedge core_reset)
   begin
      if (core_reset)
      begin
         credits   <= erx_credit_t'(`ERX_TX_CREDITS);
         out_valid <= 1'b0;
      end
      else
      begin
         case ({launch, out_credit})
            2'b10   : credits <= credits - erx_credit_t'(1);   // spent one
            2'b01   : credits <= credits + erx_credit_t'(1);   // got one back
            default : credits <= credits;                      // cancel out
         endcase
         out_valid <= launch;
      end
   end

   // payload register, only loads on launch
   always_ff @(posedge sys_clk)
   begin
      if (launch)
         out_beat <= head_beat;
   end

endmodule

`default_nettype wire

// ==== src/erx_rx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "erx_consts.svh"

module erx_rx_fifo
(
   input  wire                sys_clk,      // system clock
   input  wire                core_reset,   // flushes buffer, async
   input  wire                in_valid,     // beat from the link
   input  wire erx_pkg::erx_beat_t in_beat,  // link beat
   input  wire                pop,          // head taken by output stage
   output logic               head_valid,   // buffer not empty
   output erx_pkg::erx_beat_t head_beat,    // oldest beat
   output logic               in_credit     // one slot back to sender
);

   import erx_pkg::*;

   localparam int AW = $clog2(`ERX_FIFO_DEPTH);   // pointer width

   erx_beat_t   mem [`ERX_FIFO_DEPTH];   // beat storage
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   erx_credit_t fill;                   // beats held
   logic        full;
   logic        push;

   assign full       = (fill == erx_credit_t'(`ERX_FIFO_DEPTH));
   assign push       = in_valid && !full;   // sender holds a credit anyway
   assign head_valid = (fill != '0);
   assign head_beat  = mem[rd_ptr];         // comb read of head slot

   //####################################################################
   // storage
   //####################################################################

   always_ff @(posedge sys_clk)
   begin
      if (push)
         mem[wr_ptr] <= in_beat;
   end

   //####################################################################
   // pointers, fill level, credit return
   //####################################################################

   always_ff @(posedge sys_clk or posedge core_reset)
   begin
      if (core_reset)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         fill      <= '0;
         in_credit <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == AW'(`ERX_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == AW'(`ERX_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

         case ({push, pop})
            2'b10   : fill <= fill + erx_credit_t'(1);
            2'b01   : fill <= fill - erx_credit_t'(1);
            default : fill <= fill;            // both or neither
         endcase

         in_credit <= pop;                     // slot freed, one cycle later
      end
   end

endmodule

`default_nettype wire

// ==== src/erx_reset_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module erx_reset_fsm
(
   input  wire  sys_clk,        // system clock
   input  wire  rx_reset,       // power-on reset, async
   input  wire  heartbeat,      // pacing tick from the timer
   input  wire  soft_disable,   // software hold-off level
   input  wire  pll_locked,     // from pll, async to sys_clk
   input  wire  delay_ready,    // from delay controller, async
   output logic pll_reset,      // to pll
   output logic delay_reset,    // to delay controller
   output logic core_reset,     // receive core reset
   output logic link_up         // core out of reset
);

   import erx_pkg::*;

   logic [1:0] locked_pipe;     // two-flop sync for lock
   logic [1:0] ready_pipe;      // two-flop sync for ready
   logic       locked_sync;
   logic       ready_sync;
   erx_state_e reset_state;
   logic       raw_core_reset;  // comb, high outside active
   logic [1:0] core_pipe_n;     // shifts in ones once released

   //####################################################################
   // synchronizers
   //####################################################################

   always_ff @(posedge sys_clk or posedge rx_reset)
   begin
      if (rx_reset)
      begin
         locked_pipe <= 2'b00;
         ready_pipe  <= 2'b00;
      end
      else
      begin
         locked_pipe <= {locked_pipe[0], pll_locked};
         ready_pipe  <= {ready_pipe[0], delay_ready};
      end
   end

   assign locked_sync = locked_pipe[1];
   assign ready_sync  = ready_pipe[1];

   //####################################################################
   // sequencer, moves on heartbeats only
   //####################################################################

   always_ff @(posedge sys_clk or posedge rx_reset)
   begin
      if (rx_reset)
         reset_state <= RESET_ALL;
      else if (heartbeat)
      begin
         case (reset_state)
            RESET_ALL : if (!soft_disable)             reset_state <= START_PLL;
            START_PLL : if (locked_sync && ready_sync) reset_state <= ACTIVE;
            ACTIVE    : if (soft_disable)              reset_state <= RESET_ALL;
            default   :                                reset_state <= RESET_ALL;
         endcase
      end
   end

   assign pll_reset      = (reset_state == RESET_ALL);
   assign delay_reset    = (reset_state == RESET_ALL);   // same window as pll
   assign raw_core_reset = rx_reset | (reset_state != ACTIVE);

   // core reset pipe, async assert and sync deassert
   always_ff @(posedge sys_clk or posedge raw_core_reset)
   begin
      if (raw_core_reset)
         core_pipe_n <= 2'b00;
      else
         core_pipe_n <= {core_pipe_n[0], 1'b1};   // two cycles to release
   end

   assign core_reset = ~core_pipe_n[1];
   assign link_up    = core_pipe_n[1];

endmodule

`default_nettype wire

// ==== src/erx_heartbeat_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "erx_consts.svh"

module erx_heartbeat_timer
(
   input  wire  sys_clk,      // free-running system clock
   input  wire  rx_reset,     // power-on reset, async
   output logic heartbeat     // single-cycle tick
);

   logic [`ERX_HB_WIDTH-1:0] hb_count;   // wraps by itself

   //####################################################################
   // wrap counter and tick
   //####################################################################

   always_ff @(posedge sys_clk or posedge rx_reset)
   begin
      if (rx_reset)
      begin
         hb_count  <= '0;
         heartbeat <= 1'b0;
      end
      else
      begin
         hb_count  <= hb_count + 1'b1;           // no terminal count, just wraps
         heartbeat <= (hb_count == '0);          // registered zero detect
      end
   end

endmodule

`default_nettype wire

// ==== src/erx_pkg.sv ====
`default_nettype none

`include "erx_consts.svh"

package erx_pkg;

   //####################################################################
   // link data types
   //####################################################################

   // raw link payload
   typedef logic [`ERX_WORD_W-1:0] erx_word_t;

   // one beat on the link, in and out
   typedef struct packed {
      erx_word_t data;     // payload word
      logic      last;     // end of frame marker
   } erx_beat_t;

   // counts 0..depth inclusive, fill level and credit counters
   typedef logic [$clog2(`ERX_FIFO_DEPTH + 1)-1:0] erx_credit_t;

   // reset sequencer states
   typedef enum logic [1:0] {
      RESET_ALL = 2'b00,   // pll and delay ctrl held in reset
      START_PLL = 2'b01,   // waiting on lock and ready
      ACTIVE    = 2'b10    // core running
   } erx_state_e;

endpackage

`default_nettype wire

// ==== src/erx_consts.svh ====
`ifndef ERX_CONSTS_SVH
`define ERX_CONSTS_SVH

//####################################################################
// link receive constants
//####################################################################

// heartbeat counter width, one pulse every 2**width sys_clk cycles
// small value for simulation, widen for silicon quiet time
`define ERX_HB_WIDTH    4

// beat buffer depth, also the input credits granted at each link-up
`define ERX_FIFO_DEPTH  8

// link payload width in bits
`define ERX_WORD_W      32

// downstream credits owned by the output stage after core reset
`define ERX_TX_CREDITS  4

`endif
